// ==== calc_top.f ====
hdl/calc_cfg_pkg.sv
hdl/calc_isa_pkg.sv
hdl/calc_if.sv
hdl/issue_stage.sv
hdl/pipe_int.sv
hdl/pipe_mul.sv
hdl/completion_pipe.sv
hdl/calc_top.sv
verif/calc_top_chk.sv
verif/calc_top_tb.sv

// ==== Makefile ====
SIM        = verilator
TOP        = calc_top_tb
RTL_TOP    = calc_top
FILELIST   = calc_top.f
SIM_FLAGS  = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verif/calc_top_tb.sv ====
//********************************************************************
// Testbench for the calculator back end
// Directed and random dispatch streams checked against a register
// model built from the ISA rules, with per-test and closing reports
//********************************************************************
`timescale 1ns/1ps

module calc_top_tb;

  import calc_cfg_pkg::*;
  import calc_isa_pkg::*;

  localparam int reset_cycles_lp = 3;
  localparam int random_ops_lp   = 200;
  // Directed dispatches, idle slots and drain slack for six tests
  localparam int max_cycles_lp   = reset_cycles_lp + 2*(50 + random_ops_lp) + 6*16 + 100;

  logic                         clk_i;
  logic                         reset_i;
  logic                         dispatch_v_i;
  calc_instr_u                  instr_i;
  logic [xlen_lp-1:0]           rs1_val_i;
  logic [xlen_lp-1:0]           rs2_val_i;
  logic                         wb_v_o;
  logic [reg_addr_width_lp-1:0] wb_addr_o;
  logic [xlen_lp-1:0]           wb_data_o;
  logic                         commit_v_o;
  logic                         commit_exc_o;

  // Register values in program order, and as written back
  logic [xlen_lp-1:0]           spec_rf [32];
  logic [xlen_lp-1:0]           reg_model [32];
  int                           pend_cnt [32];
  logic [reg_addr_width_lp-1:0] wb_addr_q [$];
  logic [xlen_lp-1:0]           wb_data_q [$];
  int                           wb_cyc_q [$];
  logic                         exc_q [$];
  int                           commit_cyc_q [$];
  logic [31:0]                  rng_state = 32'hd6bcdfe3;
  int                           cycle_cnt = 0;
  int                           err_cnt = 0;
  int                           checks_cnt = 0;
  int                           tests_cnt = 0;

  calc_top calc_top_i (.*);

  bind calc_top calc_top_chk chk_i
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.commit_v_i(commit_v_o)
     ,.commit_exc_i(commit_exc_o)
     ,.wb_v_i(wb_v_o)
     );

  initial
  begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i)
    cycle_cnt <= cycle_cnt + 1;

  initial
  begin
    while (cycle_cnt < max_cycles_lp)
      @(posedge clk_i);
    $display("Timeout after %0d cycles, expected results never arrived", cycle_cnt);
    $display("Simulation FAILED");
    $finish;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // A register with a writer still in flight gets junk on its input
  function automatic logic [xlen_lp-1:0] operand_value(input logic [reg_addr_width_lp-1:0] r);
    if (pend_cnt[r] != 0)
      return next_rand();
    return reg_model[r];
  endfunction

  function automatic logic [xlen_lp-1:0] sext_imm(input logic [imm_width_lp-1:0] imm);
    return {{(xlen_lp-imm_width_lp){imm[imm_width_lp-1]}}, imm};
  endfunction

  function automatic logic [xlen_lp-1:0] isa_result(input logic [opcode_width_lp-1:0] op,
                                                    input logic [xlen_lp-1:0] a,
                                                    input logic [xlen_lp-1:0] b);
    logic [xlen_lp-1:0] y;
    case (op)
      op_add_lp, op_addi_lp: y = a + b;
      op_sub_lp:             y = a - b;
      op_and_lp:             y = a & b;
      op_or_lp:              y = a | b;
      op_xor_lp:             y = a ^ b;
      op_sll_lp:             y = a << b[4:0];
      op_srl_lp:             y = a >> b[4:0];
      op_slt_lp:             y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      op_mul_lp:             y = a * b;
      default:               y = '0;
    endcase
    return y;
  endfunction

  task automatic check_wb(input logic got_v,
                          input logic [reg_addr_width_lp-1:0] got_addr,
                          input logic [xlen_lp-1:0] got_data,
                          input logic [reg_addr_width_lp-1:0] exp_addr,
                          input logic [xlen_lp-1:0] exp_data,
                          input int exp_cycle);
    checks_cnt++;
    if (!got_v || cycle_cnt != exp_cycle)
    begin
      $display("Writeback to r%0d due in cycle %0d came in the wrong cycle", exp_addr, exp_cycle);
      err_cnt++;
    end
    else if (got_addr !== exp_addr || got_data !== exp_data)
    begin
      $display("Error at time %0t: writeback r%0d = %h, expected r%0d = %h",
               $time, got_addr, got_data, exp_addr, exp_data);
      err_cnt++;
    end
  endtask

  task automatic check_commit(input logic got_v, input logic got_exc,
                              input logic exp_exc, input int exp_cycle);
    checks_cnt++;
    if (!got_v || cycle_cnt != exp_cycle)
    begin
      $display("Commit due in cycle %0d came in the wrong cycle", exp_cycle);
      err_cnt++;
    end
    else if (got_exc !== exp_exc)
    begin
      $display("Error at time %0t: commit exception %b, expected %b", $time, got_exc, exp_exc);
      err_cnt++;
    end
  endtask

  always @(negedge clk_i)
  begin : monitor_outputs
    logic [reg_addr_width_lp-1:0] exp_addr;
    logic [xlen_lp-1:0]           exp_data;
    logic                         exp_exc;
    int                           exp_cyc;
    if (!reset_i)
    begin
      if (commit_v_o || (commit_cyc_q.size() != 0 && commit_cyc_q[0] <= cycle_cnt))
      begin
        if (commit_cyc_q.size() == 0)
        begin
          $display("Commit at time %0t with no instruction in flight", $time);
          err_cnt++;
        end
        else
        begin
          exp_exc = exc_q.pop_front();
          exp_cyc = commit_cyc_q.pop_front();
          check_commit(commit_v_o, commit_exc_o, exp_exc, exp_cyc);
        end
      end
      if (wb_v_o || (wb_cyc_q.size() != 0 && wb_cyc_q[0] <= cycle_cnt))
      begin
        if (wb_cyc_q.size() == 0)
        begin
          $display("Writeback to r%0d at time %0t with nothing pending", wb_addr_o, $time);
          err_cnt++;
        end
        else
        begin
          exp_addr = wb_addr_q.pop_front();
          exp_data = wb_data_q.pop_front();
          exp_cyc  = wb_cyc_q.pop_front();
          check_wb(wb_v_o, wb_addr_o, wb_data_o, exp_addr, exp_data, exp_cyc);
          reg_model[exp_addr] = exp_data;
          pend_cnt[exp_addr]--;
        end
      end
    end
  end

  task automatic idle_cycle();
    @(posedge clk_i);
    #2;
    dispatch_v_i = 1'b0;
  endtask

  task automatic issue_instr(input logic [opcode_width_lp-1:0] op,
                             input logic [reg_addr_width_lp-1:0] rd,
                             input logic [reg_addr_width_lp-1:0] rs1,
                             input logic [reg_addr_width_lp-1:0] rs2,
                             input logic [imm_width_lp-1:0] imm,
                             input logic squashed);
    calc_instr_u        word;
    logic [xlen_lp-1:0] res;
    word = '0;
    if (op == op_addi_lp)
    begin
      word.i.opcode = op;
      word.i.rd     = rd;
      word.i.rs1    = rs1;
      word.i.imm    = imm;
    end
    else
    begin
      word.r.opcode = op;
      word.r.rd     = rd;
      word.r.rs1    = rs1;
      word.r.rs2    = rs2;
    end
    @(posedge clk_i);
    #2;
    dispatch_v_i = 1'b1;
    instr_i      = word;
    rs1_val_i    = operand_value(word.r.rs1);
    rs2_val_i    = operand_value(word.r.rs2);
    res = isa_result(op, spec_rf[rs1], (op == op_addi_lp) ? sext_imm(imm) : spec_rf[rs2]);
    if (!squashed)
    begin
      exc_q.push_back(op > op_mul_lp);
      commit_cyc_q.push_back(cycle_cnt + 2);
      if (op <= op_mul_lp)
      begin
        wb_addr_q.push_back(rd);
        wb_data_q.push_back(res);
        wb_cyc_q.push_back(cycle_cnt + 3);
        spec_rf[rd] = res;
        pend_cnt[rd]++;
      end
    end
  endtask

  task automatic drain_pipe();
    idle_cycle();
    while (wb_cyc_q.size() != 0 || commit_cyc_q.size() != 0)
      idle_cycle();
    repeat (3) idle_cycle();
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_cnt++;
    if (err_cnt == errs_before)
      $display("%s: ok", name);
    else
      $display("%s: %0d errors", name, err_cnt - errs_before);
  endtask

  task automatic reset_and_alu_ops();
    int errs_before;
    errs_before = err_cnt;
    repeat (4) idle_cycle();
    for (int op = 0; op <= 8; op++)
      issue_instr(4'(op), 5'(10 + op), 5'(op), 5'(20 + op), 18'(next_rand()), 1'b0);
    drain_pipe();
    finish_test("reset and ALU ops", errs_before);
  endtask

  task automatic immediate_form();
    int errs_before;
    errs_before = err_cnt;
    issue_instr(op_addi_lp, 5'd1, 5'd2, 5'd0, 18'h00005, 1'b0);
    issue_instr(op_addi_lp, 5'd3, 5'd1, 5'd0, 18'h3ffff, 1'b0);
    issue_instr(op_addi_lp, 5'd4, 5'd3, 5'd0, 18'h20000, 1'b0);
    issue_instr(op_addi_lp, 5'd5, 5'd4, 5'd0, 18'h1ffff, 1'b0);
    issue_instr(op_addi_lp, 5'd6, 5'd0, 5'd0, 18'h2a5c3, 1'b0);
    issue_instr(op_add_lp, 5'd7, 5'd5, 5'd6, '0, 1'b0);
    drain_pipe();
    finish_test("immediate form", errs_before);
  endtask

  task automatic bypass_chain();
    int errs_before;
    errs_before = err_cnt;
    issue_instr(op_add_lp, 5'd5, 5'd1, 5'd2, '0, 1'b0);
    issue_instr(op_sub_lp, 5'd6, 5'd5, 5'd3, '0, 1'b0);
    issue_instr(op_xor_lp, 5'd7, 5'd4, 5'd5, '0, 1'b0);
    issue_instr(op_or_lp, 5'd8, 5'd5, 5'd6, '0, 1'b0);
    issue_instr(op_and_lp, 5'd9, 5'd8, 5'd7, '0, 1'b0);
    issue_instr(op_add_lp, 5'd5, 5'd9, 5'd9, '0, 1'b0);
    issue_instr(op_slt_lp, 5'd10, 5'd5, 5'd8, '0, 1'b0);
    issue_instr(op_sll_lp, 5'd11, 5'd7, 5'd10, '0, 1'b0);
    issue_instr(op_add_lp, 5'd5, 5'd5, 5'd5, '0, 1'b0);
    // Two writers of r5 in flight, the younger one wins
    issue_instr(op_add_lp, 5'd5, 5'd5, 5'd1, '0, 1'b0);
    issue_instr(op_add_lp, 5'd14, 5'd5, 5'd5, '0, 1'b0);
    issue_instr(op_srl_lp, 5'd15, 5'd5, 5'd14, '0, 1'b0);
    drain_pipe();
    finish_test("bypass chain", errs_before);
  endtask

  task automatic multiply_ops();
    int errs_before;
    errs_before = err_cnt;
    issue_instr(op_mul_lp, 5'd16, 5'd1, 5'd2, '0, 1'b0);
    issue_instr(op_add_lp, 5'd17, 5'd3, 5'd4, '0, 1'b0);
    issue_instr(op_add_lp, 5'd18, 5'd16, 5'd5, '0, 1'b0);
    issue_instr(op_mul_lp, 5'd19, 5'd16, 5'd18, '0, 1'b0);
    issue_instr(op_add_lp, 5'd21, 5'd6, 5'd7, '0, 1'b0);
    issue_instr(op_sub_lp, 5'd22, 5'd19, 5'd16, '0, 1'b0);
    issue_instr(op_mul_lp, 5'd23, 5'd19, 5'd22, '0, 1'b0);
    issue_instr(op_add_lp, 5'd25, 5'd8, 5'd9, '0, 1'b0);
    issue_instr(op_xor_lp, 5'd26, 5'd10, 5'd23, '0, 1'b0);
    issue_instr(op_or_lp, 5'd27, 5'd23, 5'd1, '0, 1'b0);
    drain_pipe();
    finish_test("multiply", errs_before);
  endtask

  task automatic illegal_flush();
    int errs_before;
    errs_before = err_cnt;
    issue_instr(op_add_lp, 5'd20, 5'd1, 5'd2, '0, 1'b0);
    issue_instr(4'd12, 5'd21, 5'd3, 5'd4, '0, 1'b0);
    // Squashed in the reservation, then dropped in the flush cycle
    issue_instr(op_add_lp, 5'd22, 5'd20, 5'd3, '0, 1'b1);
    issue_instr(op_add_lp, 5'd20, 5'd4, 5'd5, '0, 1'b1);
    issue_instr(op_sub_lp, 5'd23, 5'd20, 5'd22, '0, 1'b0);
    issue_instr(op_add_lp, 5'd24, 5'd23, 5'd21, '0, 1'b0);
    issue_instr(4'd15, 5'd25, 5'd0, 5'd0, '0, 1'b0);
    repeat (2) idle_cycle();
    issue_instr(op_add_lp, 5'd25, 5'd24, 5'd23, '0, 1'b0);
    drain_pipe();
    finish_test("illegal opcode flush", errs_before);
  endtask

  task automatic random_stream();
    int          errs_before;
    logic [31:0] r;
    logic [31:0] imm_r;
    errs_before = err_cnt;
    for (int n = 0; n < random_ops_lp; n++)
    begin
      r     = next_rand();
      imm_r = next_rand();
      if (r[31:29] == 3'b000)
        idle_cycle();
      // Eight registers only, so dependencies are frequent
      issue_instr(4'(r[7:0] % 8'd9), {2'b00, r[10:8]}, {2'b00, r[13:11]},
                  {2'b00, r[16:14]}, imm_r[17:0], 1'b0);
    end
    drain_pipe();
    finish_test("random stream", errs_before);
  endtask

  initial
  begin
    reset_i      = 1'b1;
    dispatch_v_i = 1'b0;
    instr_i      = '0;
    rs1_val_i    = '0;
    rs2_val_i    = '0;
    for (int r = 0; r < 32; r++)
    begin
      reg_model[r] = next_rand();
      spec_rf[r]   = reg_model[r];
      pend_cnt[r]  = 0;
    end
    repeat (reset_cycles_lp) @(posedge clk_i);
    #2;
    reset_i = 1'b0;
    reset_and_alu_ops();
    immediate_form();
    bypass_chain();
    multiply_ops();
    illegal_flush();
    random_stream();
    $display("Tests: %0d, checks: %0d, errors: %0d", tests_cnt, checks_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

// ==== verif/calc_top_chk.sv ====
//********************************************************************
// Port checks for the calculator back end
// Reset state of the strobes and writeback after each commit
//********************************************************************
`timescale 1ns/1ps

module calc_top_chk
  (input  logic   clk_i
   , input  logic reset_i
   , input  logic commit_v_i
   , input  logic commit_exc_i
   , input  logic wb_v_i
   );

  reset_quiet_a : assert property (@(posedge clk_i) reset_i |=> (!wb_v_i && !commit_v_i))
    else $error("writeback or commit strobe high right after reset");

  // A clean commit writes back in the next cycle
  commit_wb_a : assert property (@(posedge clk_i) disable iff (reset_i)
    (commit_v_i && !commit_exc_i) |=> wb_v_i)
    else $error("clean commit not followed by a writeback");

  exc_no_wb_a : assert property (@(posedge clk_i) disable iff (reset_i)
    (commit_v_i && commit_exc_i) |=> !wb_v_i)
    else $error("writeback after an exception commit");

endmodule

// ==== hdl/calc_top.sv ====
//********************************************************************
// Calculator back end top level
// Issue, integer and multiply pipes and the completion pipeline
//********************************************************************
`timescale 1ns/1ps

module calc_top
  (input  logic                                         clk_i
   , input  logic                                       reset_i
   , input  logic                                       dispatch_v_i
   , input  calc_isa_pkg::calc_instr_u                  instr_i
   , input  logic [calc_cfg_pkg::xlen_lp-1:0]           rs1_val_i
   , input  logic [calc_cfg_pkg::xlen_lp-1:0]           rs2_val_i
   , output logic                                       wb_v_o
   , output logic [calc_cfg_pkg::reg_addr_width_lp-1:0] wb_addr_o
   , output logic [calc_cfg_pkg::xlen_lp-1:0]           wb_data_o
   , output logic                                       commit_v_o
   , output logic                                       commit_exc_o
   );

  import calc_cfg_pkg::*;

  logic [xlen_lp-1:0] alu_data_lo;
  logic               illegal_lo;
  logic               mul_v_lo;
  logic [xlen_lp-1:0] mul_data_lo;
  logic               flush_lo;

  calc_rsrv_if rsrv ();
  calc_fwd_if  fwd ();

  issue_stage issue
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.dispatch_v_i(dispatch_v_i)
     ,.instr_i(instr_i)
     ,.rs1_val_i(rs1_val_i)
     ,.rs2_val_i(rs2_val_i)
     ,.flush_i(flush_lo)
     ,.fwd(fwd.issue)
     ,.rsrv(rsrv.issue)
     );

  pipe_int pipe_int_early
    (.rsrv(rsrv.pipe)
     ,.fwd(fwd.pipe)
     ,.result_o(alu_data_lo)
     ,.illegal_o(illegal_lo)
     );

  pipe_mul pipe_mul_i
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.rsrv(rsrv.pipe)
     ,.mul_v_o(mul_v_lo)
     ,.mul_data_o(mul_data_lo)
     );

  completion_pipe comp
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.rsrv(rsrv.comp)
     ,.alu_data_i(alu_data_lo)
     ,.illegal_i(illegal_lo)
     ,.mul_v_i(mul_v_lo)
     ,.mul_data_i(mul_data_lo)
     ,.fwd(fwd.comp)
     ,.flush_o(flush_lo)
     ,.commit_v_o(commit_v_o)
     ,.commit_exc_o(commit_exc_o)
     ,.wb_v_o(wb_v_o)
     ,.wb_addr_o(wb_addr_o)
     ,.wb_data_o(wb_data_o)
     );

endmodule

// ==== hdl/completion_pipe.sv ====
//********************************************************************
// Completion pipeline
// Shifts results and exception bits down the stages, injects each
// pipe's output at its stage, commits, flushes and writes back
//********************************************************************
`timescale 1ns/1ps

module completion_pipe
  (input  logic                                         clk_i
   , input  logic                                       reset_i
   , calc_rsrv_if.comp                                  rsrv
   , input  logic [calc_cfg_pkg::xlen_lp-1:0]           alu_data_i
   , input  logic                                       illegal_i
   , input  logic                                       mul_v_i
   , input  logic [calc_cfg_pkg::xlen_lp-1:0]           mul_data_i
   , calc_fwd_if.comp                                   fwd
   , output logic                                       flush_o
   , output logic                                       commit_v_o
   , output logic                                       commit_exc_o
   , output logic                                       wb_v_o
   , output logic [calc_cfg_pkg::reg_addr_width_lp-1:0] wb_addr_o
   , output logic [calc_cfg_pkg::xlen_lp-1:0]           wb_data_o
   );

  import calc_cfg_pkg::*;

  logic [pipe_stage_els_lp:1]                        stg_v_n, stg_v_r;
  logic [pipe_stage_els_lp:1]                        stg_w_v_n, stg_w_v_r;
  logic [pipe_stage_els_lp:1]                        stg_exc_n, stg_exc_r;
  logic [pipe_stage_els_lp:1][reg_addr_width_lp-1:0] stg_addr_n, stg_addr_r;
  logic [pipe_stage_els_lp:1][xlen_lp-1:0]           stg_data_n, stg_data_r;

  always_comb
  begin
    // Reservation stalls out of stage 1 during a flush
    stg_v_n[1]    = rsrv.v & ~flush_o;
    stg_w_v_n[1]  = rsrv.rd_w_v;
    stg_exc_n[1]  = 1'b0;
    stg_addr_n[1] = rsrv.rd_addr;
    stg_data_n[1] = '0;
    for (int i = 2; i <= pipe_stage_els_lp; i++)
    begin
      stg_v_n[i]    = stg_v_r[i-1];
      stg_w_v_n[i]  = stg_w_v_r[i-1];
      stg_exc_n[i]  = stg_exc_r[i-1];
      stg_addr_n[i] = stg_addr_r[i-1];
      stg_data_n[i] = stg_data_r[i-1];
    end

    stg_data_n[int_stage_lp] |= alu_data_i;
    stg_data_n[mul_stage_lp] |= mul_v_i ? mul_data_i : '0;
    stg_exc_n[int_stage_lp]  |= illegal_i;

    stg_w_v_n &= stg_v_n;
    stg_exc_n &= stg_v_n;
    stg_w_v_n[commit_stage_lp+1] &= ~stg_exc_r[commit_stage_lp];
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      stg_v_r   <= '0;
      stg_w_v_r <= '0;
      stg_exc_r <= '0;
    end
    else
    begin
      stg_v_r   <= stg_v_n;
      stg_w_v_r <= stg_w_v_n;
      stg_exc_r <= stg_exc_n;
    end
  end

  always_ff @(posedge clk_i)
  begin
    stg_addr_r <= stg_addr_n;
    stg_data_r <= stg_data_n;
  end

  assign commit_v_o   = stg_v_r[commit_stage_lp];
  assign commit_exc_o = stg_exc_r[commit_stage_lp];
  assign flush_o      = stg_v_r[commit_stage_lp] & stg_exc_r[commit_stage_lp];

  assign wb_v_o    = stg_w_v_r[pipe_stage_els_lp];
  assign wb_addr_o = stg_addr_r[pipe_stage_els_lp];
  assign wb_data_o = stg_data_r[pipe_stage_els_lp];

  // Each stage forwards the value it hands on, the last one its own
  assign fwd.stg_w_v  = stg_w_v_r;
  assign fwd.stg_addr = stg_addr_r;
  assign fwd.fwd_data = {stg_data_r[pipe_stage_els_lp], stg_data_n[pipe_stage_els_lp:2]};

endmodule

// ==== hdl/pipe_mul.sv ====
//********************************************************************
// Multiply pipe
// Registers the low word of the product, ready for stage 2
//********************************************************************
`timescale 1ns/1ps

module pipe_mul
  (input  logic                               clk_i
   , input  logic                             reset_i
   , calc_rsrv_if.pipe                        rsrv
   , output logic                             mul_v_o
   , output logic [calc_cfg_pkg::xlen_lp-1:0] mul_data_o
   );

  import calc_isa_pkg::*;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      mul_v_o <= 1'b0;
    else
      mul_v_o <= rsrv.v & (rsrv.op == op_mul_lp);
  end

  // Product truncated to the data path width
  always_ff @(posedge clk_i)
  begin
    mul_data_o <= rsrv.src1 * rsrv.src2;
  end

endmodule

// ==== hdl/pipe_int.sv ====
//********************************************************************
// Early integer pipe
// Single-cycle ALU on the reservation operands, flags illegal opcodes
//********************************************************************
`timescale 1ns/1ps

module pipe_int
  (calc_rsrv_if.pipe                          rsrv
   , calc_fwd_if.pipe                         fwd
   , output logic [calc_cfg_pkg::xlen_lp-1:0] result_o
   , output logic                             illegal_o
   );

  import calc_cfg_pkg::*;
  import calc_isa_pkg::*;

  logic [xlen_lp-1:0] alu_result;

  always_comb
  begin
    case (rsrv.op)
      op_add_lp, op_addi_lp: alu_result = rsrv.src1 + rsrv.src2;
      op_sub_lp:             alu_result = rsrv.src1 - rsrv.src2;
      op_and_lp:             alu_result = rsrv.src1 & rsrv.src2;
      op_or_lp:              alu_result = rsrv.src1 | rsrv.src2;
      op_xor_lp:             alu_result = rsrv.src1 ^ rsrv.src2;
      op_sll_lp:             alu_result = rsrv.src1 << rsrv.src2[$clog2(xlen_lp)-1:0];
      op_srl_lp:             alu_result = rsrv.src1 >> rsrv.src2[$clog2(xlen_lp)-1:0];
      op_slt_lp:
        alu_result = {{(xlen_lp-1){1'b0}}, ($signed(rsrv.src1) < $signed(rsrv.src2))};
      // Multiply and illegal opcodes leave the stage 1 data at zero
      default:               alu_result = '0;
    endcase
  end

  assign result_o     = alu_result;
  assign fwd.alu_data = alu_result;
  assign illegal_o    = rsrv.v & (rsrv.op > op_mul_lp);

endmodule

// ==== hdl/issue_stage.sv ====
//********************************************************************
// Issue stage
// Decodes the dispatched word, bypasses operands from in-flight
// instructions and loads the reservation register
//********************************************************************
`timescale 1ns/1ps

module issue_stage
  (input  logic                              clk_i
   , input  logic                            reset_i
   , input  logic                            dispatch_v_i
   , input  calc_isa_pkg::calc_instr_u       instr_i
   , input  logic [calc_cfg_pkg::xlen_lp-1:0] rs1_val_i
   , input  logic [calc_cfg_pkg::xlen_lp-1:0] rs2_val_i
   , input  logic                            flush_i
   , calc_fwd_if.issue                       fwd
   , calc_rsrv_if.issue                      rsrv
   );

  import calc_cfg_pkg::*;
  import calc_isa_pkg::*;

  logic [opcode_width_lp-1:0]                         opcode;
  logic                                               is_imm;
  logic                                               is_legal;
  logic [xlen_lp-1:0]                                 imm_ext;
  logic [1:0][reg_addr_width_lp-1:0]                  rs_addr;
  logic [1:0][xlen_lp-1:0]                            disp_val;
  logic [1:0][xlen_lp-1:0]                            bypass_val;
  logic [pipe_stage_els_lp:0]                         wr_v;
  logic [pipe_stage_els_lp:0][reg_addr_width_lp-1:0]  wr_addr;
  logic [pipe_stage_els_lp:0][xlen_lp-1:0]            wr_data;
  logic [1:0][pipe_stage_els_lp:0]                    match_rs;
  logic [1:0][pipe_stage_els_lp:0]                    match_oh;

  assign opcode   = instr_i.r.opcode;
  assign is_imm   = (opcode == op_addi_lp);
  assign is_legal = (opcode <= op_mul_lp);
  assign imm_ext  = {{(xlen_lp-imm_width_lp){instr_i.i.imm[imm_width_lp-1]}}, instr_i.i.imm};

  assign rs_addr  = {instr_i.r.rs2, instr_i.r.rs1};
  assign disp_val = {rs2_val_i, rs1_val_i};

  // Writers ordered youngest first: reservation, stage 1, stage 2
  assign wr_v    = {fwd.stg_w_v, rsrv.v & rsrv.rd_w_v};
  assign wr_addr = {fwd.stg_addr, rsrv.rd_addr};
  assign wr_data = {fwd.fwd_data, fwd.alu_data};

  always_comb
  begin
    for (int s = 0; s < 2; s++)
    begin
      for (int i = 0; i <= pipe_stage_els_lp; i++)
      begin
        match_rs[s][i] = wr_v[i] & (wr_addr[i] == rs_addr[s]);
      end
      // Keep only the lowest set bit
      match_oh[s]   = match_rs[s] & ~(match_rs[s] - (pipe_stage_els_lp+1)'(1));
      bypass_val[s] = (match_rs[s] == '0) ? disp_val[s] : '0;
      for (int i = 0; i <= pipe_stage_els_lp; i++)
      begin
        bypass_val[s] |= match_oh[s][i] ? wr_data[i] : '0;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i | flush_i)
      rsrv.v <= 1'b0;
    else
      rsrv.v <= dispatch_v_i;
  end

  always_ff @(posedge clk_i)
  begin
    rsrv.op      <= opcode;
    rsrv.src1    <= bypass_val[0];
    rsrv.src2    <= is_imm ? imm_ext : bypass_val[1];
    rsrv.rd_addr <= instr_i.r.rd;
    rsrv.rd_w_v  <= is_legal;
  end

endmodule

// ==== hdl/calc_if.sv ====
//********************************************************************
// Back end interfaces
// Reservation register contents and completion forwarding state
//********************************************************************
`timescale 1ns/1ps

interface calc_rsrv_if;
  import calc_cfg_pkg::*;
  import calc_isa_pkg::*;

  logic                         v;
  logic [opcode_width_lp-1:0]   op;
  logic [xlen_lp-1:0]           src1;
  logic [xlen_lp-1:0]           src2;
  logic [reg_addr_width_lp-1:0] rd_addr;
  logic                         rd_w_v;

  modport issue (output v, op, src1, src2, rd_addr, rd_w_v);
  modport pipe  (input v, op, src1, src2);
  modport comp  (input v, rd_addr, rd_w_v);
endinterface

interface calc_fwd_if;
  import calc_cfg_pkg::*;

  logic [pipe_stage_els_lp:1]                        stg_w_v;
  logic [pipe_stage_els_lp:1][reg_addr_width_lp-1:0] stg_addr;
  logic [pipe_stage_els_lp:1][xlen_lp-1:0]           fwd_data;
  logic [xlen_lp-1:0]                                alu_data;

  modport issue (input stg_w_v, stg_addr, fwd_data, alu_data);
  modport comp  (output stg_w_v, stg_addr, fwd_data);
  modport pipe  (output alu_data);
endinterface

// ==== hdl/calc_isa_pkg.sv ====
//********************************************************************
// Instruction set of the calculator back end
// Opcode encodings and the two views of one instruction word
//********************************************************************

package calc_isa_pkg;

  localparam int opcode_width_lp = 4;
  localparam int imm_width_lp    = 18;
  localparam int unused_width_lp = calc_cfg_pkg::instr_width_lp - opcode_width_lp
                                   - 3*calc_cfg_pkg::reg_addr_width_lp;

  localparam logic [opcode_width_lp-1:0] op_add_lp  = 4'd0;
  localparam logic [opcode_width_lp-1:0] op_sub_lp  = 4'd1;
  localparam logic [opcode_width_lp-1:0] op_and_lp  = 4'd2;
  localparam logic [opcode_width_lp-1:0] op_or_lp   = 4'd3;
  localparam logic [opcode_width_lp-1:0] op_xor_lp  = 4'd4;
  localparam logic [opcode_width_lp-1:0] op_sll_lp  = 4'd5;
  localparam logic [opcode_width_lp-1:0] op_srl_lp  = 4'd6;
  localparam logic [opcode_width_lp-1:0] op_slt_lp  = 4'd7;
  localparam logic [opcode_width_lp-1:0] op_addi_lp = 4'd8;
  // Anything above multiply is illegal
  localparam logic [opcode_width_lp-1:0] op_mul_lp  = 4'd9;

  typedef union packed {
    struct packed {
      logic [unused_width_lp-1:0]                unused;
      logic [calc_cfg_pkg::reg_addr_width_lp-1:0] rs2;
      logic [calc_cfg_pkg::reg_addr_width_lp-1:0] rs1;
      logic [calc_cfg_pkg::reg_addr_width_lp-1:0] rd;
      logic [opcode_width_lp-1:0]                opcode;
    } r;
    struct packed {
      logic [imm_width_lp-1:0]                   imm;
      logic [calc_cfg_pkg::reg_addr_width_lp-1:0] rs1;
      logic [calc_cfg_pkg::reg_addr_width_lp-1:0] rd;
      logic [opcode_width_lp-1:0]                opcode;
    } i;
  } calc_instr_u;

endpackage

// ==== hdl/calc_cfg_pkg.sv ====
//********************************************************************
// Pipeline configuration for the calculator back end
// Widths, completion stage count and the stage where each pipe's
// result joins the completion pipeline
//********************************************************************

package calc_cfg_pkg;

  localparam int xlen_lp           = 32;
  localparam int reg_addr_width_lp = 5;
  localparam int instr_width_lp    = 32;

  // Completion stages that follow the reservation register
  localparam int pipe_stage_els_lp = 2;
  localparam int int_stage_lp      = 1;
  localparam int mul_stage_lp      = 2;
  localparam int commit_stage_lp   = 1;

endpackage
